//--- filelist.f
+incdir+source
source/lt_pkg.sv
source/raster_position.sv
source/column_adder_tree.sv
source/window_accumulator.sv
source/threshold_decider.sv
source/local_threshold_top.sv
verification/local_threshold_properties.sv
verification/local_threshold_tb.sv

//--- Bender.yml
package:
  name: local_threshold

sources:
  - include_dirs:
      - source
    files:
      - source/lt_pkg.sv
      - source/raster_position.sv
      - source/column_adder_tree.sv
      - source/window_accumulator.sv
      - source/threshold_decider.sv
      - source/local_threshold_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/local_threshold_properties.sv
      - verification/local_threshold_tb.sv

//--- verification/local_threshold_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lt_cfg.svh"

module local_threshold_tb
    import lt_pkg::*;
;

    localparam int N_CASES = 5;
    localparam int TIMEOUT = N_CASES * `LT_COLS * `LT_ROWS * 4 + 200;
    localparam int K_CONST = 0;
    localparam int K_RAMP  = 1;
    localparam int K_RAND  = 2;

    typedef struct packed {
        logic [1:0] kind;
        logic [7:0] level;
        logic       gaps;    // random idle cycles between strobes
    } case_t;

    typedef struct packed {
        logic [31:0]              due;
        logic [`LT_WIN_SUM_W-1:0] win_sum;
        logic [7:0]               centre;
        logic                     foreground;
        logic [5:0]               col_idx;
        logic [2:0]               row_idx;
    } expect_t;

    logic          clk;
    logic          rst;
    logic          i_col_valid;
    pixel_column_t i_col;
    logic          o_valid;
    lt_result_t    o_result;
    logic          o_frame_done;

    case_t         cases [N_CASES];
    pixel_column_t frame [`LT_ROWS][`LT_COLS];
    expect_t       exp_q [$];
    logic [31:0]   done_q [$];
    logic [31:0]   data_lfsr;
    logic [31:0]   gap_lfsr;
    int            cycle;
    int            errors;
    int            checks;
    int            results;

    local_threshold_top local_threshold_top_inst (
        .clk          (clk),
        .rst          (rst),
        .i_col_valid  (i_col_valid),
        .i_col        (i_col),
        .o_valid      (o_valid),
        .o_result     (o_result),
        .o_frame_done (o_frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout after %0d cycles, results still outstanding", cycle);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, inout logic [31:0] state, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            state = next_lfsr(state);
            value = {value[6:0], state[0]};
        end
    endtask

    // ##########################################################################
    // frame contents and the reference model
    // ##########################################################################

    task automatic build_frame(input case_t c);
        logic [7:0] v;
        for (int b = 0; b < `LT_ROWS; b++) begin
            for (int x = 0; x < `LT_COLS; x++) begin
                for (int y = 0; y < `LT_WIN; y++) begin
                    case (c.kind)
                        K_CONST: v = c.level;
                        K_RAMP:  v = 8'(x * 7 + y * 3 + b * 40);
                        default: take_bits(8, data_lfsr, v);
                    endcase
                    frame[b][x][y] = v;
                end
            end
        end
    endtask

    function automatic expect_t model_window(input int b, input int x, input int due);
        expect_t e;
        int      sum;
        sum = 0;
        for (int cx = x - (`LT_WIN - 1); cx <= x; cx++) begin
            for (int y = 0; y < `LT_WIN; y++) begin
                sum = sum + frame[b][cx][y];
            end
        end
        e.due        = due;
        e.win_sum    = sum;
        e.centre     = frame[b][x - `LT_WIN / 2][`LT_WIN / 2];
        e.foreground = (e.centre * 289 > sum);
        e.col_idx    = x;
        e.row_idx    = b;
        return e;
    endfunction

    task automatic send_frame(input case_t c);
        logic [7:0] gap;
        for (int b = 0; b < `LT_ROWS; b++) begin
            for (int x = 0; x < `LT_COLS; x++) begin
                gap = '0;
                if (c.gaps) begin
                    take_bits(2, gap_lfsr, gap);
                end
                repeat (gap) begin
                    @(posedge clk);
                    #1 i_col_valid = 1'b0;
                end
                @(posedge clk);
                #1;
                i_col_valid = 1'b1;
                i_col       = frame[b][x];
                if (x >= `LT_WIN - 1) begin
                    exp_q.push_back(model_window(b, x, cycle + 7));    // due seven cycles on
                end
                if (b == `LT_ROWS - 1 && x == `LT_COLS - 1) begin
                    done_q.push_back(cycle + 7);
                end
            end
        end
        @(posedge clk);
        #1 i_col_valid = 1'b0;
    endtask

    // ##########################################################################
    // output checks, sampled away from the active edge
    // ##########################################################################

    task automatic check_field(input string name, input int got, input int want);
        checks++;
        assert (got == want) else begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        expect_t e;
        if (!rst && o_valid) begin
            results++;
            assert (exp_q.size() != 0) else begin
                $display("result at %0t with no column waiting for one", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_field("result cycle", cycle, e.due);
                check_field("o_result.win_sum", o_result.win_sum, e.win_sum);
                check_field("o_result.centre", o_result.centre, e.centre);
                check_field("o_result.foreground", o_result.foreground, e.foreground);
                check_field("o_result.col_idx", o_result.col_idx, e.col_idx);
                check_field("o_result.row_idx", o_result.row_idx, e.row_idx);
            end
        end
        if (!rst && o_frame_done) begin
            assert (done_q.size() != 0) else begin
                $display("frame done at %0t with no frame end pending", $time);
                errors++;
            end
            if (done_q.size() != 0) begin
                check_field("o_frame_done cycle", cycle, done_q.pop_front());
            end
        end
    end

    initial begin
        int case_errors;
        cases[0] = '{kind: K_CONST, level: 8'd100, gaps: 1'b0};
        cases[1] = '{kind: K_RAND,  level: 8'd0,   gaps: 1'b0};
        cases[2] = '{kind: K_RAND,  level: 8'd0,   gaps: 1'b1};    // same data as case 1
        cases[3] = '{kind: K_RAMP,  level: 8'd0,   gaps: 1'b0};
        cases[4] = '{kind: K_CONST, level: 8'd255, gaps: 1'b1};
        cycle       = 0;
        errors      = 0;
        checks      = 0;
        results     = 0;
        gap_lfsr    = 32'h4184;
        rst         = 1'b1;
        i_col_valid = 1'b0;
        i_col       = '0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        for (int n = 0; n < N_CASES; n++) begin
            case_errors = errors;
            results     = 0;
            data_lfsr   = 32'h4184;
            build_frame(cases[n]);
            send_frame(cases[n]);
            while (exp_q.size() != 0 || done_q.size() != 0) begin
                @(posedge clk);
            end
            repeat (2) @(posedge clk);
            check_field("result count", results, `LT_ROWS * (`LT_COLS - `LT_WIN + 1));
            $display("case %0d: %0d results, %0d errors", n, results, errors - case_errors);
        end

        $display("%0d cases, %0d checks, %0d errors", N_CASES, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/local_threshold_properties.sv
`timescale 1ns/1ps
`default_nettype none

module local_threshold_properties (
    input wire clk,
    input wire rst,
    input wire i_col_valid,
    input wire o_valid,
    input wire o_frame_done
);

    // outputs stay quiet while reset is applied and one cycle after
    assert property (@(posedge clk) rst |=> (!o_valid && !o_frame_done))
        else $error("output strobe seen during or right after reset");

    // every result belongs to a column strobed seven cycles before
    assert property (@(posedge clk) disable iff (rst) o_valid |-> $past(i_col_valid, 7))
        else $error("result without a column strobe seven cycles earlier");

    assert property (@(posedge clk) disable iff (rst) o_frame_done |=> !o_frame_done)
        else $error("frame done strobe wider than one cycle");

endmodule

bind local_threshold_top local_threshold_properties local_threshold_properties_inst (
    .clk          (clk),
    .rst          (rst),
    .i_col_valid  (i_col_valid),
    .o_valid      (o_valid),
    .o_frame_done (o_frame_done)
);

`default_nettype wire

//--- source/local_threshold_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "lt_cfg.svh"

module local_threshold_top
    import lt_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire                i_col_valid,
    input  wire pixel_column_t i_col,
    output logic               o_valid,
    output lt_result_t         o_result,
    output logic               o_frame_done
);

    col_tag_t  col_tag;     // tag of the column on the input
    tree_out_t tree;
    window_t   window;

    raster_position raster_position_inst (
        .clk         (clk),
        .rst         (rst),
        .i_col_valid (i_col_valid),
        .o_tag       (col_tag)
    );

    column_adder_tree column_adder_tree_inst (
        .clk         (clk),
        .rst         (rst),
        .i_col_valid (i_col_valid),
        .i_col       (i_col),
        .i_tag       (col_tag),
        .o_tree      (tree)
    );

    window_accumulator window_accumulator_inst (
        .clk      (clk),
        .rst      (rst),
        .i_tree   (tree),
        .o_window (window)
    );

    threshold_decider threshold_decider_inst (
        .clk          (clk),
        .rst          (rst),
        .i_window     (window),
        .o_valid      (o_valid),
        .o_result     (o_result),
        .o_frame_done (o_frame_done)
    );

endmodule

`default_nettype wire

//--- source/threshold_decider.sv
`timescale 1ns/1ps
`default_nettype none
`include "lt_cfg.svh"

module threshold_decider
    import lt_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire window_t i_window,
    output logic         o_valid,
    output lt_result_t   o_result,
    output logic         o_frame_done
);

    localparam int SUM_W = `LT_WIN_SUM_W;
    localparam int PIX_W = `LT_PIX_W;
    localparam logic [SUM_W-1:0] AREA = SUM_W'(`LT_WIN * `LT_WIN);

    logic [SUM_W-1:0] scaled;
    logic             foreground;
    logic             full;

    // centre above the local mean, compared without a divide
    assign scaled     = {{(SUM_W-PIX_W){1'b0}}, i_window.centre} * AREA;
    assign foreground = (scaled > i_window.win_sum);
    assign full       = i_window.valid & i_window.tag.window_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid      <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            o_valid      <= full;
            o_frame_done <= i_window.valid & i_window.tag.last_of_frame;
        end
    end

    always_ff @(posedge clk) begin
        if (full) begin
            o_result.win_sum    <= i_window.win_sum;
            o_result.centre     <= i_window.centre;
            o_result.foreground <= foreground;
            o_result.col_idx    <= i_window.tag.col_idx;
            o_result.row_idx    <= i_window.tag.row_idx;
        end
    end

endmodule

`default_nettype wire

//--- source/window_accumulator.sv
`timescale 1ns/1ps
`default_nettype none
`include "lt_cfg.svh"

module window_accumulator
    import lt_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire tree_out_t i_tree,
    output window_t        o_window
);

    localparam int CSUM_W = `LT_COL_SUM_W;
    localparam int WSUM_W = `LT_WIN_SUM_W;
    localparam int DEPTH  = `LT_WIN;
    localparam int MID    = `LT_WIN / 2;

    logic [CSUM_W-1:0]    csum_line [DEPTH];
    logic [`LT_PIX_W-1:0] ctr_line [MID+1];
    logic [WSUM_W-1:0]    win_sum_q;
    logic [WSUM_W-1:0]    csum_new;
    logic [WSUM_W-1:0]    csum_old;
    logic                 vld_q;
    col_tag_t             tag_q;

    assign csum_new = {{(WSUM_W-CSUM_W){1'b0}}, i_tree.col_sum};
    assign csum_old = {{(WSUM_W-CSUM_W){1'b0}}, csum_line[DEPTH-1]};    // 17 columns back

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= i_tree.valid;
        end
    end

    // ########################################################################
    // running sum over the last LT_WIN column sums
    // ########################################################################

    always_ff @(posedge clk) begin
        tag_q <= i_tree.tag;
        if (i_tree.valid) begin
            if (i_tree.tag.first_of_row) begin
                win_sum_q <= csum_new;
                for (int i = 1; i < DEPTH; i++) begin
                    csum_line[i] <= '0;    // partial windows then subtract zero
                end
            end else begin
                win_sum_q <= win_sum_q + csum_new - csum_old;
                for (int i = 1; i < DEPTH; i++) begin
                    csum_line[i] <= csum_line[i-1];
                end
            end
            csum_line[0] <= i_tree.col_sum;
        end
    end

    // centre pixels of the newest nine columns, the oldest is the middle one
    always_ff @(posedge clk) begin
        if (i_tree.valid) begin
            ctr_line[0] <= i_tree.centre;
            for (int i = 1; i <= MID; i++) begin
                ctr_line[i] <= ctr_line[i-1];
            end
        end
    end

    assign o_window = '{
        valid:   vld_q,
        tag:     tag_q,
        win_sum: win_sum_q,
        centre:  ctr_line[MID]
    };

endmodule

`default_nettype wire

//--- source/column_adder_tree.sv
`timescale 1ns/1ps
`default_nettype none
`include "lt_cfg.svh"

module column_adder_tree
    import lt_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire                i_col_valid,
    input  wire pixel_column_t i_col,
    input  wire col_tag_t      i_tag,
    output tree_out_t          o_tree
);

    localparam int PIX_W  = `LT_PIX_W;
    localparam int SUM_W  = `LT_COL_SUM_W;
    localparam int CENTRE = `LT_WIN / 2;
    localparam int LAST   = `LT_WIN - 1;

    pixel_column_t    st1_col;
    logic [PIX_W:0]   lvl2_q [8];
    logic [PIX_W+1:0] lvl3_q [4];
    logic [PIX_W+2:0] lvl4_q [2];
    logic [SUM_W-1:0] sum_q;
    logic [PIX_W-1:0] tail_q [3];     // the odd pixel waits for the last level
    logic [PIX_W-1:0] ctr_q [4];
    logic [4:0]       vld_q;
    col_tag_t         tag_q [5];

    // one valid bit per stage keeps up to five columns apart
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[3:0], i_col_valid};
        end
    end

    // ########################################################################
    // stage 1 registers the column, stages 2 to 5 are the pairwise levels
    // ########################################################################

    always_ff @(posedge clk) begin
        st1_col <= i_col;
        for (int i = 0; i < 8; i++) begin
            lvl2_q[i] <= {1'b0, st1_col[2*i]} + {1'b0, st1_col[2*i+1]};
        end
        for (int i = 0; i < 4; i++) begin
            lvl3_q[i] <= {1'b0, lvl2_q[2*i]} + {1'b0, lvl2_q[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            lvl4_q[i] <= {1'b0, lvl3_q[2*i]} + {1'b0, lvl3_q[2*i+1]};
        end
        sum_q <= {2'b00, lvl4_q[0]} + {2'b00, lvl4_q[1]}
               + {{(SUM_W-PIX_W){1'b0}}, tail_q[2]};
    end

    always_ff @(posedge clk) begin
        tail_q[0] <= st1_col[LAST];
        tail_q[1] <= tail_q[0];
        tail_q[2] <= tail_q[1];
    end

    // ########################################################################
    // tag and centre pixel ride along with the sums
    // ########################################################################

    always_ff @(posedge clk) begin
        tag_q[0] <= i_tag;
        for (int i = 1; i < 5; i++) begin
            tag_q[i] <= tag_q[i-1];
        end
        ctr_q[0] <= st1_col[CENTRE];    // enters at stage 2 next to the first level
        for (int i = 1; i < 4; i++) begin
            ctr_q[i] <= ctr_q[i-1];
        end
    end

    assign o_tree = '{
        valid:   vld_q[4],
        tag:     tag_q[4],
        col_sum: sum_q,
        centre:  ctr_q[3]
    };

endmodule

`default_nettype wire

//--- source/raster_position.sv
`timescale 1ns/1ps
`default_nettype none
`include "lt_cfg.svh"

module raster_position
    import lt_pkg::*;
(
    input  wire      clk,
    input  wire      rst,
    input  wire      i_col_valid,
    output col_tag_t o_tag
);

    logic [5:0] col_cnt;
    logic [2:0] row_cnt;
    logic       col_last;
    logic       row_last;

    assign col_last = (col_cnt == 6'(`LT_COLS - 1));
    assign row_last = (row_cnt == 3'(`LT_ROWS - 1));

    // ########################################################################
    // column and band counters, stepped once per column strobe
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_col_valid) begin
            if (col_last) begin
                col_cnt <= '0;
                row_cnt <= row_last ? 3'd0 : row_cnt + 3'd1;    // wraps into the next frame
            end else begin
                col_cnt <= col_cnt + 6'd1;
            end
        end
    end

    // the tag describes the column on the input right now
    always_comb begin
        o_tag.col_idx       = col_cnt;
        o_tag.row_idx       = row_cnt;
        o_tag.first_of_row  = (col_cnt == 6'd0);
        o_tag.window_full   = (col_cnt >= 6'(`LT_WIN - 1));
        o_tag.last_of_frame = col_last & row_last;
    end

endmodule

`default_nettype wire

//--- source/lt_pkg.sv
`default_nettype none
`include "lt_cfg.svh"

package lt_pkg;

    // index 0 is the top pixel of the column and index 8 the centre
    typedef logic [`LT_WIN-1:0][`LT_PIX_W-1:0] pixel_column_t;

    typedef struct packed {
        logic [5:0] col_idx;
        logic [2:0] row_idx;
        logic       first_of_row;
        logic       window_full;     // at least LT_WIN columns seen in this band
        logic       last_of_frame;
    } col_tag_t;

    typedef struct packed {
        logic                     valid;
        col_tag_t                 tag;
        logic [`LT_COL_SUM_W-1:0] col_sum;
        logic [`LT_PIX_W-1:0]     centre;    // pixel 8 of this column
    } tree_out_t;

    typedef struct packed {
        logic                     valid;
        col_tag_t                 tag;
        logic [`LT_WIN_SUM_W-1:0] win_sum;
        logic [`LT_PIX_W-1:0]     centre;    // centre pixel of the middle column
    } window_t;

    typedef struct packed {
        logic [`LT_WIN_SUM_W-1:0] win_sum;
        logic [`LT_PIX_W-1:0]     centre;
        logic                     foreground;
        logic [5:0]               col_idx;
        logic [2:0]               row_idx;
    } lt_result_t;

endpackage

`default_nettype wire

//--- source/lt_cfg.svh
`ifndef LT_CFG_SVH
`define LT_CFG_SVH

// one column of LT_WIN pixels arrives per strobe
`define LT_WIN        17
`define LT_PIX_W      8

// columns per row band and row bands per frame
`define LT_COLS       32
`define LT_ROWS       4

// 17 pixels of 255 fit in 13 bits
`define LT_COL_SUM_W  13

// 289 pixels of 255 fit in 17 bits
`define LT_WIN_SUM_W  17

`endif
